/* tb/exmem_stim.txt */
# test alu_op rs1 rs2 rd imm use_imm mem_en mem_write reg_write expected_wb (all hex)
# alu_op 0 ADD 1 SUB 2 AND 3 OR 4 XOR 5 SHL 6 SHR 7 PASSB, a dash marks a store
1 7 0 0 1 1234 1 0 0 1 1234
1 7 0 0 2 00ff 1 0 0 1 00ff
1 7 0 0 3 0f0f 1 0 0 1 0f0f
1 7 0 0 4 0003 1 0 0 1 0003
2 0 1 1 6 0000 0 0 0 1 2468
2 1 6 2 7 0000 0 0 0 1 2369
2 4 7 6 8 0000 0 0 0 1 0701
2 5 8 4 9 0000 0 0 0 1 3808
2 6 9 0 a 0004 1 0 0 1 0380
3 7 4 a 0 0010 1 1 1 0 -
3 7 4 0 d 0010 1 1 0 1 0380
3 7 0 0 e 5a5a 1 0 0 1 5a5a
3 0 1 1 f 0000 0 0 0 1 2468
3 7 4 e 0 0020 1 1 1 0 -
3 7 4 0 d 0020 1 1 0 1 5a5a
4 7 4 0 1 0010 1 1 0 1 0380
4 0 1 2 2 0000 0 0 0 1 047f
4 7 4 0 6 0020 1 1 0 1 5a5a
4 3 2 6 7 0000 0 0 0 1 5e7f
5 7 0 0 8 beef 1 0 0 1 beef
5 7 4 8 0 0040 1 1 1 0 -
5 7 4 0 9 0040 1 1 0 1 beef
5 0 9 7 b 0000 0 0 0 1 1d6e
5 7 4 b 0 0041 1 1 1 0 -
5 7 4 0 c 0041 1 1 0 1 1d6e

/* src.f */
hdl/cpu_pkg.sv
hdl/wb_pkg.sv
hdl/issue_regfile.sv
hdl/ex_stage.sv
hdl/ex_mem_pipe_reg.sv
hdl/mem_wb_stage.sv
hdl/exmem_core_top.sv
tb/exmem_core_properties.sv
tb/tb_exmem_core.sv

/* Makefile */
# Verilator flow for the EX/MEM back end testbench

VERILATOR ?= verilator
TOP       ?= tb_exmem_core
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST)) tb/exmem_stim.txt
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/tb_exmem_core.sv */
module tb_exmem_core
  import cpu_pkg::*, wb_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int    NTEST         = 5;
  localparam int    RESET_CYCLES  = 16;
  localparam int    CYCLES_PER_OP = 20;    // Watchdog budget for each stimulus line
  localparam string STIM_FILE     = "tb/exmem_stim.txt";

  // One expected register write, kept in issue order
  typedef struct packed {
    logic [3:0] test;
    reg_id_t    rd;
    word_t      data;
  } exp_t;

  logic      clk;
  logic      arst_n;
  logic      issue_valid;
  issue_op_t issue_op;
  logic      issue_ready;
  wb_req_t   wb_req;
  wb_rsp_t   wb_rsp;
  logic      wb_valid;
  reg_id_t   wb_rd;
  word_t     wb_data;

  issue_op_t ops [$];                      // Operations in file order
  int        op_test [$];                  // Test number of each operation
  exp_t      exp_q [$];
  exp_t      exp_e;
  int        exp_total [1:NTEST];
  int        done_cnt [1:NTEST];
  int        err_cnt [1:NTEST];
  int        stall_cnt [1:NTEST];          // Interlock cycles of an offered operation
  int        errors;                       // Failures outside any single test
  int        next_op;
  int        seed = 12884;
  int        wait_left;                    // Wait states left before the next ack
  word_t     mem [1024];

  exmem_core_top #(
    .ADR_W(10)
  ) exmem_core_i (
    .clk(clk), .arst_n(arst_n),
    .issue_valid(issue_valid), .issue_op(issue_op), .issue_ready(issue_ready),
    .wb_req(wb_req), .wb_rsp(wb_rsp),
    .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Wishbone memory model with random wait states
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    wb_rsp    = '0;
    wait_left = 0;
    for (int a = 0; a < 1024; a++) begin
      mem[a] = word_t'(a * 16'h9e37) ^ 16'h0c3a;  // Different word at every address
    end
  end

  always @(posedge clk) begin
    if (!arst_n) begin
      wb_rsp <= '0;
    end else if (wb_rsp.ack) begin
      wb_rsp.ack <= 1'b0;                  // Transfer ended on this edge
    end else if (wb_req.cyc && wb_req.stb) begin
      if (wait_left == 0) begin
        wb_rsp.ack <= 1'b1;
        // Only whole-word transfers are modeled
        if (wb_req.sel !== 2'b11) begin
          $display("MISMATCH wb_req.sel: got %h, expected %h", wb_req.sel, 2'b11);
          errors++;
        end
        if (wb_req.we) begin
          mem[wb_req.adr[9:0]] <= wb_req.dat_w;
        end else begin
          wb_rsp.dat_r <= mem[wb_req.adr[9:0]];
        end
        wait_left <= int'($unsigned($random(seed)) % 4); // Delay of the next access
      end else begin
        wait_left <= wait_left - 1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Issue port driver and write-back checker
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (arst_n) begin
      if (issue_valid && issue_ready) begin
        next_op++;                         // Offered operation taken on this edge
      end
      if (next_op < ops.size()) begin
        issue_valid <= 1'b1;
        issue_op    <= ops[next_op];
      end else begin
        issue_valid <= 1'b0;
      end
    end
  end

  function automatic string test_name(int t);
    case (t)
      1:       return "independent ALU operations";
      2:       return "dependent ALU operations";
      3:       return "store then load";
      4:       return "load followed by use";
      default: return "memory under wait states";
    endcase
  endfunction

  task automatic report_test(int t);
    if (t == 4 && stall_cnt[t] == 0) begin
      $display("Test 4 error: issue_ready never went low for the load-use case");
      err_cnt[t]++;
    end
    $display("Test %0d (%s): %0d write-backs, %0d errors, %s", t, test_name(t),
             done_cnt[t], err_cnt[t], (err_cnt[t] == 0) ? "PASS" : "FAIL");
  endtask

  // Outputs settle after the rising edge, so they are sampled on the falling one
  always @(negedge clk) begin
    // A low issue_ready with no bus cycle waiting comes from the load-use interlock
    if (arst_n && next_op < ops.size() && issue_valid && !issue_ready &&
        !(wb_req.cyc && !wb_rsp.ack)) begin
      stall_cnt[op_test[next_op]]++;
    end
    if (arst_n && wb_valid) begin
      if (exp_q.size() == 0) begin
        $display("Unexpected write-back to r%0d with data %h", wb_rd, wb_data);
        errors++;
      end else begin
        exp_e = exp_q.pop_front();
        if (wb_rd !== exp_e.rd) begin
          $display("MISMATCH wb_rd: got %h, expected %h", wb_rd, exp_e.rd);
          err_cnt[exp_e.test]++;
        end
        if (wb_data !== exp_e.data) begin
          $display("MISMATCH wb_data: got %h, expected %h (r%0d)", wb_data, exp_e.data,
                   exp_e.rd);
          err_cnt[exp_e.test]++;
        end
        done_cnt[exp_e.test]++;
        if (done_cnt[exp_e.test] == exp_total[exp_e.test]) begin
          report_test(int'(exp_e.test));
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus file, reset and end of run
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_stim();
    int              fd;
    int              n;
    int              code;
    logic [8*128-1:0] line;
    logic [31:0]     f [11];
    issue_op_t       o;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file %s", STIM_FILE);
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = '0;
        code = $fgets(line, fd);
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
                    f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
        if (code > 0 && n >= 10) begin     // Comment lines hold no hex fields
          o.alu_op    = alu_op_e'(f[1][2:0]);
          o.rs1       = f[2][3:0];
          o.rs2       = f[3][3:0];
          o.rd        = f[4][3:0];
          o.imm       = f[5][15:0];
          o.use_imm   = f[6][0];
          o.mem_en    = f[7][0];
          o.mem_write = f[8][0];
          o.reg_write = f[9][0];
          ops.push_back(o);
          op_test.push_back(int'(f[0]));
          if (n == 11) begin               // A dash in the last column means no write-back
            exp_q.push_back('{test: f[0][3:0], rd: o.rd, data: f[10][15:0]});
            exp_total[f[0]]++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    int total;
    arst_n      = 1'b0;
    issue_valid = 1'b0;
    issue_op    = '0;
    errors      = 0;
    next_op     = 0;
    load_stim();

    fork
      begin
        repeat (RESET_CYCLES + ops.size() * CYCLES_PER_OP) @(posedge clk);
        $display("Timeout: the write-backs did not all arrive in time");
        $display("Test failed");
        $finish;
      end
    join_none

    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    if (!issue_ready || wb_req.cyc || wb_req.stb || wb_valid) begin
      $display("Wrong state after reset: issue_ready low, a bus cycle open or wb_valid high");
      errors++;
    end

    while (exp_q.size() != 0 || next_op < ops.size()) @(posedge clk);
    repeat (8) @(posedge clk);             // Catch any extra write-back

    total = errors;
    for (int t = 1; t <= NTEST; t++) begin
      total += err_cnt[t];
    end
    $display("Summary: %0d operations, %0d errors", ops.size(), total);
    if (total == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* tb/exmem_core_properties.sv */
module exmem_core_properties
  import cpu_pkg::*, wb_pkg::*;
(
  input logic      clk,
  input logic      arst_n,
  input wb_req_t   wb_req,
  input wb_rsp_t   wb_rsp,
  input logic      issue_ready,
  input issue_op_t id_op,                  // Operation held in the ID stage
  input logic      id_valid
);
  timeunit 1ns;
  timeprecision 1ps;

  // Wishbone classic rules on the data port
  stb_needs_cyc: assert property (@(posedge clk) disable iff (!arst_n)
    wb_req.stb |-> wb_req.cyc) else $error("stb high without cyc");

  req_stable: assert property (@(posedge clk) disable iff (!arst_n)
    (wb_req.cyc && !wb_rsp.ack) |=>
      (wb_req.cyc && $stable({wb_req.we, wb_req.adr, wb_req.dat_w, wb_req.sel})))
    else $error("Request changed before ack");

  cyc_low_reset: assert property (@(posedge clk)
    (!arst_n || $rose(arst_n)) |-> !wb_req.cyc) else $error("cyc high in or after reset");

  // The ID stage takes nothing while issue_ready is low
  no_accept: assert property (@(posedge clk) disable iff (!arst_n)
    !issue_ready |=> ($stable(id_op) && $stable(id_valid)))
    else $error("Operation accepted while issue_ready was low");

endmodule

bind mem_wb_stage exmem_core_properties bus_props_i (
  .clk(clk), .arst_n(arst_n), .wb_req(wb_req), .wb_rsp(wb_rsp),
  .issue_ready(1'b1), .id_op('0), .id_valid(1'b0)
);

bind issue_regfile exmem_core_properties issue_props_i (
  .clk(clk), .arst_n(arst_n), .wb_req('0), .wb_rsp('0),
  .issue_ready(issue_ready), .id_op(id_op), .id_valid(id_valid)
);

/* hdl/exmem_core_top.sv */
module exmem_core_top
  import cpu_pkg::*, wb_pkg::*;
#(
  parameter int unsigned ADR_W = 10        // Data memory of 1024 words
) (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      issue_valid,
  input  issue_op_t issue_op,
  output logic      issue_ready,
  output wb_req_t   wb_req,                // Data memory port
  input  wb_rsp_t   wb_rsp,
  output logic      wb_valid,              // Register write of the retiring operation
  output reg_id_t   wb_rd,
  output word_t     wb_data
);

  id_ex_t  id_ex;
  logic    id_ex_valid;
  ex_mem_t ex_out;                         // Execute result before the EX/MEM register
  ex_mem_t ex_mem;
  wb_t     wb;
  logic    mem_busy;

  issue_regfile issue_regfile_i (
    .clk(clk), .arst_n(arst_n),
    .issue_valid(issue_valid), .issue_op(issue_op), .issue_ready(issue_ready),
    .hold(mem_busy), .wb(wb), .id_ex(id_ex), .id_ex_valid(id_ex_valid)
  );

  ex_stage ex_stage_i (
    .id_ex(id_ex), .id_ex_valid(id_ex_valid),
    .fwd_mem(ex_mem), .fwd_wb(wb), .ex_out(ex_out)
  );

  ex_mem_pipe_reg ex_mem_pipe_reg_i (
    .clk(clk), .arst_n(arst_n), .hold(mem_busy),
    .ex_in(ex_out), .wb(wb), .ex_mem(ex_mem)
  );

  mem_wb_stage #(
    .ADR_W(ADR_W)
  ) mem_wb_stage_i (
    .clk(clk), .arst_n(arst_n), .ex_mem(ex_mem),
    .wb_req(wb_req), .wb_rsp(wb_rsp), .mem_busy(mem_busy), .wb(wb)
  );

  assign wb_valid = wb.valid;
  assign wb_rd    = wb.rd;
  assign wb_data  = wb.data;

endmodule

/* hdl/mem_wb_stage.sv */
module mem_wb_stage
  import cpu_pkg::*, wb_pkg::*;
#(
  parameter int unsigned ADR_W = 10        // Word address width of the data memory
) (
  input  logic    clk,
  input  logic    arst_n,
  input  ex_mem_t ex_mem,
  output wb_req_t wb_req,                  // Wishbone classic master port
  input  wb_rsp_t wb_rsp,
  output logic    mem_busy,                // Holds the whole back end
  output wb_t     wb
);

  typedef enum logic {
    IDLE,                                  // No cycle started in an earlier clock
    BUS                                    // Cycle open, waiting for ack
  } bus_state_e;

  bus_state_e       state;
  logic             cyc;
  logic [ADR_W-1:0] word_adr;
  logic             wb_valid_q;
  reg_id_t          wb_rd_q;
  word_t            wb_data_q;

  ////////////////////////////////////////////////////////////////////////////
  // Wishbone master
  ////////////////////////////////////////////////////////////////////////////

  // A cycle starts as soon as a memory operation reaches EX/MEM
  assign cyc      = (state == BUS) | ex_mem.mem_en;
  assign mem_busy = cyc & ~wb_rsp.ack;     // Access not acknowledged yet
  assign word_adr = ex_mem.alu_out[ADR_W-1:0];

  always_comb begin
    wb_req                = '0;
    wb_req.cyc            = cyc;
    wb_req.stb            = cyc;           // Single transfer per cycle
    wb_req.we             = ex_mem.mem_write;
    wb_req.adr[ADR_W-1:0] = word_adr;
    wb_req.dat_w          = ex_mem.store_data;
    wb_req.sel            = 2'b11;         // Whole words only
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:    if (ex_mem.mem_en && !wb_rsp.ack) state <= BUS;
        BUS:     if (wb_rsp.ack) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // MEM/WB register and result select
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_valid_q <= 1'b0;
    end else if (!mem_busy) begin
      wb_valid_q <= ex_mem.reg_write;
    end
  end

  always_ff @(posedge clk) begin
    if (!mem_busy) begin
      wb_rd_q   <= ex_mem.rd;
      wb_data_q <= ex_mem.mem_to_reg ? wb_rsp.dat_r : ex_mem.alu_out; // Load data or ALU
    end
  end

  // The result counts once, in the cycle before the pipeline moves on
  assign wb = '{valid: wb_valid_q & ~mem_busy, rd: wb_rd_q, data: wb_data_q};

endmodule

/* hdl/ex_mem_pipe_reg.sv */
module ex_mem_pipe_reg
  import cpu_pkg::*;
(
  input  logic    clk,
  input  logic    arst_n,
  input  logic    hold,                    // Keep the contents while the bus is busy
  input  ex_mem_t ex_in,                   // Result of the execute stage
  input  wb_t     wb,                      // Value being written back this cycle
  output ex_mem_t ex_mem
);

  logic    newer_wr;                       // Operation now in EX/MEM also writes rs2
  logic    store_fwd;
  word_t   store_data;
  word_t   alu_out_q;
  word_t   store_data_q;
  reg_id_t rs2_q;
  reg_id_t rd_q;
  logic    mem_en_q;
  logic    mem_write_q;
  logic    reg_write_q;
  logic    mem_to_reg_q;

  // Write-back data replaces the store data unless a younger write to rs2 was forwarded
  assign newer_wr   = ex_mem.reg_write & (ex_mem.rd == ex_in.rs2);
  assign store_fwd  = ex_in.mem_write & wb.valid & (wb.rd == ex_in.rs2) & ~newer_wr;
  assign store_data = store_fwd ? wb.data : ex_in.store_data;

  // Enables of the memory and write-back stages
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mem_en_q     <= 1'b0;
      mem_write_q  <= 1'b0;
      reg_write_q  <= 1'b0;
      mem_to_reg_q <= 1'b0;
    end else if (!hold) begin
      mem_en_q     <= ex_in.mem_en;
      mem_write_q  <= ex_in.mem_write;
      reg_write_q  <= ex_in.reg_write;
      mem_to_reg_q <= ex_in.mem_to_reg;
    end
  end

  always_ff @(posedge clk) begin
    if (!hold) begin
      alu_out_q    <= ex_in.alu_out;
      store_data_q <= store_data;
      rs2_q        <= ex_in.rs2;
      rd_q         <= ex_in.rd;
    end
  end

  assign ex_mem = '{alu_out: alu_out_q, store_data: store_data_q, rs2: rs2_q, rd: rd_q,
                    mem_en: mem_en_q, mem_write: mem_write_q, reg_write: reg_write_q,
                    mem_to_reg: mem_to_reg_q};

endmodule

/* hdl/ex_stage.sv */
module ex_stage
  import cpu_pkg::*;
(
  input  id_ex_t  id_ex,
  input  logic    id_ex_valid,             // Low for a bubble
  input  ex_mem_t fwd_mem,                 // Operation one stage ahead
  input  wb_t     fwd_wb,                  // Operation two stages ahead
  output ex_mem_t ex_out
);

  logic  mem_hit_a;                        // EX/MEM writes rs1
  logic  mem_hit_b;                        // EX/MEM writes rs2
  logic  wb_hit_a;
  logic  wb_hit_b;
  logic  is_store;
  logic  is_load;
  word_t op_a;
  word_t rs2_fwd;                          // rs2 with forwarding from both stages
  word_t op_b;
  word_t result;
  word_t mem_adr;

  ////////////////////////////////////////////////////////////////////////////
  // Operand forwarding
  ////////////////////////////////////////////////////////////////////////////

  // Loads in EX/MEM have no value yet and never match here
  assign mem_hit_a = fwd_mem.reg_write & ~fwd_mem.mem_to_reg & (fwd_mem.rd == id_ex.op.rs1);
  assign mem_hit_b = fwd_mem.reg_write & ~fwd_mem.mem_to_reg & (fwd_mem.rd == id_ex.op.rs2);
  assign wb_hit_a  = fwd_wb.valid & (fwd_wb.rd == id_ex.op.rs1);
  assign wb_hit_b  = fwd_wb.valid & (fwd_wb.rd == id_ex.op.rs2);

  // The younger EX/MEM value takes priority over MEM/WB
  assign op_a    = mem_hit_a ? fwd_mem.alu_out : (wb_hit_a ? fwd_wb.data : id_ex.rs1_val);
  assign rs2_fwd = mem_hit_b ? fwd_mem.alu_out : (wb_hit_b ? fwd_wb.data : id_ex.rs2_val);
  assign op_b    = id_ex.op.use_imm ? id_ex.op.imm : rs2_fwd;

  ////////////////////////////////////////////////////////////////////////////
  // ALU and address adder
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (id_ex.op.alu_op)
      ADD:     result = op_a + op_b;
      SUB:     result = op_a - op_b;
      AND:     result = op_a & op_b;
      OR:      result = op_a | op_b;
      XOR:     result = op_a ^ op_b;
      SHL:     result = op_a << op_b[3:0];
      SHR:     result = op_a >> op_b[3:0];
      default: result = op_b;              // PASSB
    endcase
  end

  assign mem_adr  = op_a + id_ex.op.imm;   // Base register plus offset
  assign is_store = id_ex.op.mem_en & id_ex.op.mem_write;
  assign is_load  = id_ex.op.mem_en & ~id_ex.op.mem_write;

  always_comb begin
    ex_out.alu_out    = id_ex.op.mem_en ? mem_adr : result;
    // MEM/WB forwarding of store data happens in the EX/MEM register
    ex_out.store_data = mem_hit_b ? fwd_mem.alu_out : id_ex.rs2_val;
    ex_out.rs2        = id_ex.op.rs2;
    ex_out.rd         = id_ex.op.rd;
    ex_out.mem_en     = id_ex_valid & id_ex.op.mem_en;       // A bubble clears every enable
    ex_out.mem_write  = id_ex_valid & is_store;
    ex_out.reg_write  = id_ex_valid & id_ex.op.reg_write & ~is_store;
    ex_out.mem_to_reg = id_ex_valid & is_load;
  end

endmodule

/* hdl/issue_regfile.sv */
module issue_regfile
  import cpu_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  logic      issue_valid,           // Operation offered at the issue port
  input  issue_op_t issue_op,
  output logic      issue_ready,
  input  logic      hold,                  // Back end frozen by an open bus cycle
  input  wb_t       wb,                    // Register file write port
  output id_ex_t    id_ex,
  output logic      id_ex_valid
);

  word_t     regs [16];                    // The 16 general registers
  issue_op_t id_op;                        // Operation waiting for its operands
  logic      id_valid;
  logic      ex_is_load;                   // ID/EX holds a load that writes a register
  logic      uses_rs2;
  logic      load_use;
  word_t     rs1_val;
  word_t     rs2_val;

  ////////////////////////////////////////////////////////////////////////////
  // Register file
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (wb.valid) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // A value written in this cycle is seen by the read at once
  assign rs1_val = (wb.valid && wb.rd == id_op.rs1) ? wb.data : regs[id_op.rs1];
  assign rs2_val = (wb.valid && wb.rd == id_op.rs2) ? wb.data : regs[id_op.rs2];

  ////////////////////////////////////////////////////////////////////////////
  // Load-use interlock and issue handshake
  ////////////////////////////////////////////////////////////////////////////

  assign ex_is_load = id_ex_valid & id_ex.op.mem_en & ~id_ex.op.mem_write & id_ex.op.reg_write;
  assign uses_rs2   = ~id_op.use_imm | (id_op.mem_en & id_op.mem_write); // Stores read rs2
  assign load_use   = id_valid & ex_is_load &
                      ((id_ex.op.rd == id_op.rs1) | (uses_rs2 & (id_ex.op.rd == id_op.rs2)));

  assign issue_ready = ~hold & ~load_use;  // ID stage can take a new operation

  // The ID stage keeps its operation during a stall
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      id_valid <= 1'b0;
    end else if (issue_ready) begin
      id_valid <= issue_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid && issue_ready) begin
      id_op <= issue_op;
    end
  end

  // ID/EX register, a bubble goes in while the interlock holds the ID stage
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      id_ex_valid <= 1'b0;
    end else if (!hold) begin
      id_ex_valid <= id_valid & ~load_use;
    end
  end

  always_ff @(posedge clk) begin
    if (!hold) begin
      id_ex <= '{op: id_op, rs1_val: rs1_val, rs2_val: rs2_val};
    end
  end

endmodule

/* hdl/wb_pkg.sv */
package wb_pkg;

  typedef logic [15:0] wb_adr_t;           // Word address, a master uses the low bits
  typedef logic [15:0] wb_dat_t;           // One 16-bit data word per transfer
  typedef logic [1:0]  wb_sel_t;           // One select bit per byte lane

  // Signals driven by the master
  typedef struct packed {
    logic    cyc;                          // Bus cycle in progress
    logic    stb;                          // Valid transfer on the bus
    logic    we;                           // Write when set
    wb_adr_t adr;
    wb_dat_t dat_w;
    wb_sel_t sel;
  } wb_req_t;

  // Signals driven by the slave
  typedef struct packed {
    logic    ack;                          // Transfer ends on this edge
    wb_dat_t dat_r;
  } wb_rsp_t;

endpackage

/* hdl/cpu_pkg.sv */
package cpu_pkg;

  typedef logic [15:0] word_t;             // One data word of the CPU
  typedef logic [3:0]  reg_id_t;           // Register number, 16 registers in all

  // Operations of the execute stage ALU
  typedef enum logic [2:0] {
    ADD   = 3'd0,
    SUB   = 3'd1,
    AND   = 3'd2,
    OR    = 3'd3,
    XOR   = 3'd4,
    SHL   = 3'd5,                          // Shift amount from the low 4 bits of B
    SHR   = 3'd6,                          // Logical shift, zeros come in at the top
    PASSB = 3'd7                           // B straight through, used for load immediate
  } alu_op_e;

  ////////////////////////////////////////////////////////////////////////////
  // Contents of the pipeline stages
  ////////////////////////////////////////////////////////////////////////////

  // Decoded operation as it arrives at the issue port
  typedef struct packed {
    alu_op_e alu_op;
    reg_id_t rs1;                          // First source, also the base of an address
    reg_id_t rs2;                          // Second source, also the data of a store
    reg_id_t rd;
    word_t   imm;
    logic    use_imm;                      // B operand taken from imm instead of rs2
    logic    mem_en;                       // Load or store
    logic    mem_write;                    // Store when set together with mem_en
    logic    reg_write;
  } issue_op_t;

  // ID/EX register with the operands read from the register file
  typedef struct packed {
    issue_op_t op;
    word_t     rs1_val;
    word_t     rs2_val;
  } id_ex_t;

  // EX/MEM register
  typedef struct packed {
    word_t   alu_out;                      // ALU result or word address of the access
    word_t   store_data;
    reg_id_t rs2;                          // Kept for store data forwarding
    reg_id_t rd;
    logic    mem_en;
    logic    mem_write;
    logic    reg_write;
    logic    mem_to_reg;                   // Result comes from the data memory
  } ex_mem_t;

  // Result leaving the write-back stage
  typedef struct packed {
    logic    valid;
    reg_id_t rd;
    word_t   data;
  } wb_t;

endpackage
